/* rtl/scalar_defs.svh */
`ifndef SCALAR_DEFS_SVH
`define SCALAR_DEFS_SVH

// Operand and result width
`define SCALAR_DATA_WIDTH 32

// Fraction bits, Q16.16
`define SCALAR_FRAC_BITS 16

// APB byte address width
`define SCALAR_ADDR_WIDTH 8

`endif

/* rtl/scalar_bus_pkg.sv */
`include "scalar_defs.svh"

package scalar_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // Byte addresses, word aligned
  typedef enum logic [`SCALAR_ADDR_WIDTH-1:0] {
    CTRL      = 8'h00,
    OPERAND_A = 8'h04,
    OPERAND_B = 8'h08,
    STATUS    = 8'h0C,
    RESULT    = 8'h10
  } reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // APB request
  //////////////////////////////////////////////////////////////////////

  // Master to slave half of the bus
  typedef struct packed {
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`SCALAR_ADDR_WIDTH-1:0] paddr;
    logic [`SCALAR_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

endpackage

/* rtl/scalar_arith_pkg.sv */
`include "scalar_defs.svh"

package scalar_arith_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////////////////////////

  // CTRL bits 1:0
  // Encoding 2'b11 unused, runs as add
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } opcode_t;

  //////////////////////////////////////////////////////////////////////
  // Datapath bundles
  //////////////////////////////////////////////////////////////////////

  // Signed Q16.16 operand pair
  typedef struct packed {
    logic signed [`SCALAR_DATA_WIDTH-1:0] a;
    logic signed [`SCALAR_DATA_WIDTH-1:0] b;
  } operands_t;

  // Unit result with signed overflow flag
  typedef struct packed {
    logic [`SCALAR_DATA_WIDTH-1:0] value;
    logic                          overflow;
  } result_t;

endpackage

/* rtl/scalar_fixed_adder.sv */
`timescale 1ns/1ns
`include "scalar_defs.svh"

module scalar_fixed_adder (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic                        sub_select,
  input  scalar_arith_pkg::operands_t operands,
  output logic                        ready,
  output scalar_arith_pkg::result_t   result
);

  localparam int W = `SCALAR_DATA_WIDTH;

  // Step 0 waits for start, step 1 computes
  typedef enum logic {IDLE, COMPUTE} state_t;

  state_t                      state;
  scalar_arith_pkg::operands_t ops_q;
  logic                        sub_q;
  logic [W-1:0]                b_eff;
  logic [W-1:0]                sum;
  logic                        ovf;

  // Subtract as a + ~b + 1
  assign b_eff = sub_q ? ~ops_q.b : ops_q.b;
  assign sum   = ops_q.a + b_eff + {{(W-1){1'b0}}, sub_q};

  // Same sign in, other sign out
  assign ovf = (ops_q.a[W-1] == b_eff[W-1]) && (sum[W-1] != ops_q.a[W-1]);

  // FSM and ready pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      ready <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          ready <= 1'b0;
          if (start) begin
            state <= COMPUTE;
          end
        end
        COMPUTE: begin
          ready <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operand latch and result hold
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      ops_q <= operands;
      sub_q <= sub_select;
    end
    if (state == COMPUTE) begin
      result.value    <= sum;
      result.overflow <= ovf;
    end
  end

endmodule

/* rtl/scalar_fixed_multiplier.sv */
`timescale 1ns/1ns
`include "scalar_defs.svh"

module scalar_fixed_multiplier (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  scalar_arith_pkg::operands_t operands,
  output logic                        ready,
  output scalar_arith_pkg::result_t   result
);

  localparam int W     = `SCALAR_DATA_WIDTH;
  localparam int CNT_W = $clog2(W);

  typedef enum logic [1:0] {IDLE, ITERATE, FINISH} state_t;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  state_t                  state;
  logic [CNT_W-1:0]        count;
  logic                    last_step;

  // Full width product accumulator
  logic signed [2*W-1:0]   acc;
  // Sign extended multiplicand, shifts left
  logic signed [2*W-1:0]   mcand;
  // Multiplier bits, shift right
  logic [W-1:0]            mplier;
  logic signed [2*W-1:0]   partial;
  // Product rescaled to Q16.16
  logic signed [2*W-1:0]   scaled;
  // Bits that must all match the result sign
  logic [W:0]              top_bits;
  logic                    ovf;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  assign last_step = (count == CNT_W'(W-1));

  // Top bit of b weighs -2^(W-1), so the last step subtracts
  assign partial = mplier[0] ? (last_step ? acc - mcand : acc + mcand) : acc;

  // Arithmetic shift, rounds toward minus infinity
  assign scaled   = acc >>> `SCALAR_FRAC_BITS;
  assign top_bits = scaled[2*W-1:W-1];
  assign ovf      = ~((&top_bits) | ~(|top_bits));

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      count <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        IDLE: begin
          count <= '0;
          if (start) begin
            state <= ITERATE;
          end
        end
        ITERATE: begin
          // One multiplier bit per cycle
          count <= count + 1'b1;
          if (last_step) begin
            state <= FINISH;
          end
        end
        FINISH: begin
          ready <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift registers, accumulator and result hold
  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (start) begin
          acc    <= '0;
          mcand  <= {{W{operands.a[W-1]}}, operands.a};
          mplier <= operands.b;
        end
      end
      ITERATE: begin
        acc    <= partial;
        mcand  <= mcand <<< 1;
        mplier <= mplier >> 1;
      end
      FINISH: begin
        result.value    <= scaled[W-1:0];
        result.overflow <= ovf;
      end
      default: ;
    endcase
  end

endmodule

/* rtl/scalar_control.sv */
`timescale 1ns/1ns
`include "scalar_defs.svh"

module scalar_control (
  input  logic                          CLK,
  input  logic                          RST,
  input  scalar_bus_pkg::apb_req_t      apb_req,
  output logic [`SCALAR_DATA_WIDTH-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  output scalar_arith_pkg::operands_t   operands,
  output logic                          add_start,
  output logic                          sub_select,
  output logic                          mul_start,
  input  logic                          add_ready,
  input  scalar_arith_pkg::result_t     add_result,
  input  logic                          mul_ready,
  input  scalar_arith_pkg::result_t     mul_result
);

  localparam int W = `SCALAR_DATA_WIDTH;

  // CTRL start bit
  localparam int CTRL_START_BIT = 4;

  typedef enum logic [1:0] {IDLE, DISPATCH, WAIT} seq_state_t;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  seq_state_t                state;
  logic                      busy;
  logic                      done;

  // Software visible registers
  logic [W-1:0]              operand_a;
  logic [W-1:0]              operand_b;
  scalar_arith_pkg::opcode_t opcode_q;
  scalar_arith_pkg::result_t result_q;

  // Opcode of the operation in flight
  scalar_arith_pkg::opcode_t active_op;
  logic                      unit_ready;
  scalar_arith_pkg::result_t unit_result;

  // APB decode
  scalar_bus_pkg::reg_addr_t addr;
  logic                      access;
  logic                      mapped;
  logic                      read_only;
  logic                      start_req;
  logic                      wr_en;
  logic                      start_go;

  //////////////////////////////////////////////////////////////////////
  // APB slave
  //////////////////////////////////////////////////////////////////////

  assign addr   = scalar_bus_pkg::reg_addr_t'(apb_req.paddr);
  assign access = apb_req.psel & apb_req.penable;

  always_comb begin
    case (addr)
      scalar_bus_pkg::CTRL,
      scalar_bus_pkg::OPERAND_A,
      scalar_bus_pkg::OPERAND_B,
      scalar_bus_pkg::STATUS,
      scalar_bus_pkg::RESULT: mapped = 1'b1;
      default:                mapped = 1'b0;
    endcase
  end

  assign read_only = (addr == scalar_bus_pkg::STATUS) | (addr == scalar_bus_pkg::RESULT);
  assign start_req = access & apb_req.pwrite & (addr == scalar_bus_pkg::CTRL) &
                     apb_req.pwdata[CTRL_START_BIT];

  // Start while busy waits with pready low
  assign pready  = access & ~(start_req & busy);
  assign pslverr = pready & (~mapped | (apb_req.pwrite & read_only));

  // Accepted, error free write
  assign wr_en    = pready & apb_req.pwrite & ~pslverr;
  assign start_go = wr_en & start_req;

  // Read mux
  always_comb begin
    prdata = '0;
    if (access && !apb_req.pwrite) begin
      case (addr)
        scalar_bus_pkg::CTRL:      prdata = {{(W-2){1'b0}}, opcode_q};
        scalar_bus_pkg::OPERAND_A: prdata = operand_a;
        scalar_bus_pkg::OPERAND_B: prdata = operand_b;
        // Overflow, done, busy in bits 2:0
        scalar_bus_pkg::STATUS:    prdata = {{(W-3){1'b0}}, result_q.overflow, done, busy};
        scalar_bus_pkg::RESULT:    prdata = result_q.value;
        default:                   prdata = '0;
      endcase
    end
  end

  // Operand registers, snapshot to the units on start
  always_ff @(posedge CLK) begin
    if (wr_en && addr == scalar_bus_pkg::OPERAND_A) begin
      operand_a <= apb_req.pwdata;
    end
    if (wr_en && addr == scalar_bus_pkg::OPERAND_B) begin
      operand_b <= apb_req.pwdata;
    end
    // Held until the unit answers
    if (start_go) begin
      operands.a <= operand_a;
      operands.b <= operand_b;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  assign busy = (state != IDLE);

  // Route by opcode, 2'b11 falls to the adder
  assign add_start  = (state == DISPATCH) & (active_op != scalar_arith_pkg::OP_MUL);
  assign mul_start  = (state == DISPATCH) & (active_op == scalar_arith_pkg::OP_MUL);
  assign sub_select = (active_op == scalar_arith_pkg::OP_SUB);

  // Only the started unit counts
  assign unit_ready  = (active_op == scalar_arith_pkg::OP_MUL) ? mul_ready : add_ready;
  assign unit_result = (active_op == scalar_arith_pkg::OP_MUL) ? mul_result : add_result;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      done      <= 1'b0;
      opcode_q  <= scalar_arith_pkg::OP_ADD;
      active_op <= scalar_arith_pkg::OP_ADD;
      result_q  <= '0;
    end else begin
      if (wr_en && addr == scalar_bus_pkg::CTRL) begin
        opcode_q <= scalar_arith_pkg::opcode_t'(apb_req.pwdata[1:0]);
      end
      case (state)
        IDLE: begin
          if (start_go) begin
            active_op <= scalar_arith_pkg::opcode_t'(apb_req.pwdata[1:0]);
            done      <= 1'b0;
            state     <= DISPATCH;
          end
        end
        // Start pulse goes out here
        DISPATCH: state <= WAIT;
        WAIT: begin
          if (unit_ready) begin
            result_q <= unit_result;
            done     <= 1'b1;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* rtl/scalar_accelerator.sv */
`timescale 1ns/1ns
`include "scalar_defs.svh"

module scalar_accelerator (
  input  logic                          CLK,
  input  logic                          RST,
  input  scalar_bus_pkg::apb_req_t      apb_req,
  output logic [`SCALAR_DATA_WIDTH-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr
);

  // Control to units
  scalar_arith_pkg::operands_t operands;
  logic                        add_start;
  logic                        sub_select;
  logic                        mul_start;

  // Units to control
  logic                        add_ready;
  scalar_arith_pkg::result_t   add_result;
  logic                        mul_ready;
  scalar_arith_pkg::result_t   mul_result;

  // APB registers and sequencing
  scalar_control u_control (
    .CLK        (CLK),
    .RST        (RST),
    .apb_req    (apb_req),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .operands   (operands),
    .add_start  (add_start),
    .sub_select (sub_select),
    .mul_start  (mul_start),
    .add_ready  (add_ready),
    .add_result (add_result),
    .mul_ready  (mul_ready),
    .mul_result (mul_result)
  );

  // Add and subtract, two cycles
  scalar_fixed_adder u_adder (
    .CLK        (CLK),
    .RST        (RST),
    .start      (add_start),
    .sub_select (sub_select),
    .operands   (operands),
    .ready      (add_ready),
    .result     (add_result)
  );

  // Shift-add multiply
  scalar_fixed_multiplier u_multiplier (
    .CLK        (CLK),
    .RST        (RST),
    .start      (mul_start),
    .operands   (operands),
    .ready      (mul_ready),
    .result     (mul_result)
  );

endmodule

/* testbench/scalar_accelerator_sva.sv */
`timescale 1ns/1ns

module scalar_accelerator_sva (
  input logic CLK,
  input logic RST,
  input logic pready,
  input logic pslverr,
  input logic add_start,
  input logic mul_start,
  input logic add_ready,
  input logic mul_ready,
  input logic busy
);

  // Count of failed assertions
  int assert_failures = 0;

  ////////////////////////////////////////////////////////////////////
  // Start pulses
  ////////////////////////////////////////////////////////////////////

  // One cycle each
  a_add_pulse: assert property (@(posedge CLK) disable iff (RST) add_start |=> !add_start)
    else begin
      $error("add_start high for more than one cycle");
      assert_failures++;
    end
  a_mul_pulse: assert property (@(posedge CLK) disable iff (RST) mul_start |=> !mul_start)
    else begin
      $error("mul_start high for more than one cycle");
      assert_failures++;
    end

  // Only one unit started at a time
  a_one_unit: assert property (@(posedge CLK) disable iff (RST) !(add_start && mul_start))
    else begin
      $error("add_start and mul_start high together");
      assert_failures++;
    end

  ////////////////////////////////////////////////////////////////////
  // Bus and completion
  ////////////////////////////////////////////////////////////////////

  a_err_ready: assert property (@(posedge CLK) disable iff (RST) pslverr |-> pready)
    else begin
      $error("pslverr high without pready");
      assert_failures++;
    end

  // Readies only answer an operation in flight
  a_add_busy: assert property (@(posedge CLK) disable iff (RST) add_ready |-> busy)
    else begin
      $error("add_ready while not busy");
      assert_failures++;
    end
  a_mul_busy: assert property (@(posedge CLK) disable iff (RST) mul_ready |-> busy)
    else begin
      $error("mul_ready while not busy");
      assert_failures++;
    end

endmodule

bind scalar_control scalar_accelerator_sva u_sva (
  .CLK       (CLK),
  .RST       (RST),
  .pready    (pready),
  .pslverr   (pslverr),
  .add_start (add_start),
  .mul_start (mul_start),
  .add_ready (add_ready),
  .mul_ready (mul_ready),
  .busy      (busy)
);

/* testbench/scalar_accelerator_tb.sv */
`timescale 1ns/1ns
`include "scalar_defs.svh"

module scalar_accelerator_tb;

  localparam int W            = `SCALAR_DATA_WIDTH;
  localparam int N_FIXED      = 10;
  localparam int N_RANDOM     = 6;
  localparam int N_TESTS      = N_FIXED + N_RANDOM;
  localparam int BUS_TIMEOUT  = 100;
  localparam int POLL_TIMEOUT = 100;

  // One table row with stimulus and expectation
  typedef struct packed {
    scalar_arith_pkg::opcode_t op;
    logic [W-1:0]              a;
    logic [W-1:0]              b;
    logic [W-1:0]              exp_value;
    logic                      exp_ovf;
  } test_vec_t;

  logic                     CLK;
  logic                     RST;
  scalar_bus_pkg::apb_req_t apb_req;
  logic [W-1:0]             prdata;
  logic                     pready;
  logic                     pslverr;

  test_vec_t vectors [N_TESTS];
  int        test_errors;
  int        pass_count;
  int        fail_count;
  bit        timed_out;

  scalar_accelerator dut (
    .CLK     (CLK),
    .RST     (RST),
    .apb_req (apb_req),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // 100 ns clock
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference arithmetic
  //////////////////////////////////////////////////////////////////////

  // Exact 64-bit math followed by wrap and range check
  function automatic scalar_arith_pkg::result_t expected_result(
    input scalar_arith_pkg::opcode_t op, input logic [W-1:0] a, input logic [W-1:0] b);
    longint                    sa;
    longint                    sb;
    longint                    full;
    scalar_arith_pkg::result_t r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      scalar_arith_pkg::OP_SUB: full = sa - sb;
      // Floor division by 2^16
      scalar_arith_pkg::OP_MUL: full = (sa * sb) >>> `SCALAR_FRAC_BITS;
      default:                  full = sa + sb;
    endcase
    r.value    = full[W-1:0];
    r.overflow = (full > 64'sd2147483647) || (full < -64'sd2147483648);
    return r;
  endfunction

  function automatic test_vec_t vector_row(input scalar_arith_pkg::opcode_t op,
    input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] v, input logic o);
    test_vec_t t;
    t.op        = op;
    t.a         = a;
    t.b         = b;
    t.exp_value = v;
    t.exp_ovf   = o;
    return t;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////////////////////////

  // Setup and access phases until pready
  // Stall counts the cycles with pready low
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
    input logic [W-1:0] wdata, output logic [W-1:0] rdata, output logic err,
    output int stall);
    int cycles;
    cycles = 0;
    rdata  = '0;
    err    = 1'b0;
    stall  = 0;
    if (timed_out) return;
    @(posedge CLK);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    // Sample mid cycle
    // Transfer ends on the next rising edge
    @(negedge CLK);
    while (!pready && cycles < BUS_TIMEOUT) begin
      cycles++;
      @(negedge CLK);
    end
    if (!pready) begin
      $display("Timeout: no pready within %0d cycles at address %h", BUS_TIMEOUT, addr);
      timed_out = 1'b1;
    end else begin
      rdata = prdata;
      err   = pslverr;
      stall = cycles;
      @(posedge CLK);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [W-1:0] data,
    output logic err, output int stall);
    logic [W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err, stall);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [W-1:0] data, output logic err);
    int stall;
    apb_transfer(1'b0, addr, '0, data, err, stall);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Operations and checks
  //////////////////////////////////////////////////////////////////////

  task automatic start_op(input scalar_arith_pkg::opcode_t op, output int stall);
    logic err;
    // Start in bit 4 and opcode in bits 1:0
    apb_write(scalar_bus_pkg::CTRL, {{(W-5){1'b0}}, 1'b1, 2'b00, op}, err, stall);
  endtask

  task automatic load_operands(input logic [W-1:0] a, input logic [W-1:0] b);
    logic err;
    int   stall;
    apb_write(scalar_bus_pkg::OPERAND_A, a, err, stall);
    apb_write(scalar_bus_pkg::OPERAND_B, b, err, stall);
  endtask

  // Poll STATUS until done
  task automatic wait_done();
    logic [W-1:0] status;
    logic         err;
    int           polls;
    polls  = 0;
    status = '0;
    while (!status[1] && !timed_out && polls < POLL_TIMEOUT) begin
      apb_read(scalar_bus_pkg::STATUS, status, err);
      polls++;
    end
    if (!status[1] && !timed_out) begin
      $display("Timeout: operation not done after %0d status polls", POLL_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic compare(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
    if (!timed_out && got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0 && !timed_out) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: mismatch or abort", name);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned               seed;
    logic [1:0]                op_bits;
    scalar_arith_pkg::opcode_t op;
    logic [W-1:0]              a;
    logic [W-1:0]              b;
    scalar_arith_pkg::result_t r;
    logic [W-1:0]              rdata;
    logic                      err;
    int                        stall;

    apb_req     = '0;
    RST         = 1'b1;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    timed_out   = 1'b0;
    seed        = $urandom(32'hbb66);

    // Hand computed Q16.16 rows
    vectors[0] = vector_row(scalar_arith_pkg::OP_ADD, 32'h00018000, 32'h00024000, 32'h0003C000, 0);
    vectors[1] = vector_row(scalar_arith_pkg::OP_SUB, 32'h00010000, 32'h00038000, 32'hFFFD8000, 0);
    vectors[2] = vector_row(scalar_arith_pkg::OP_ADD, 32'hFFFF4000, 32'h00004000, 32'hFFFF8000, 0);
    // Signed overflow with wrapped value
    vectors[3] = vector_row(scalar_arith_pkg::OP_ADD, 32'h7FFF0000, 32'h00020000, 32'h80010000, 1);
    vectors[4] = vector_row(scalar_arith_pkg::OP_SUB, 32'h40000000, 32'hC0000000, 32'h80000000, 1);
    // Multiply with mixed signs and truncation
    vectors[5] = vector_row(scalar_arith_pkg::OP_MUL, 32'h00028000, 32'hFFFE8000, 32'hFFFC4000, 0);
    vectors[6] = vector_row(scalar_arith_pkg::OP_MUL, 32'h00000001, 32'hFFFF8000, 32'hFFFFFFFF, 0);
    vectors[7] = vector_row(scalar_arith_pkg::OP_MUL, 32'h00000003, 32'h00008000, 32'h00000001, 0);
    vectors[8] = vector_row(scalar_arith_pkg::OP_MUL, 32'h01000000, 32'h01000000, 32'h00000000, 1);
    // Exactly the most negative value without overflow
    vectors[9] = vector_row(scalar_arith_pkg::OP_MUL, 32'h00800000, 32'hFF000000, 32'h80000000, 0);

    for (int i = N_FIXED; i < N_TESTS; i++) begin
      op_bits = 2'($urandom % 3);
      op      = scalar_arith_pkg::opcode_t'(op_bits);
      a       = $urandom;
      b       = $urandom;
      // Narrow multiplier so some products stay in range
      if (op == scalar_arith_pkg::OP_MUL) begin
        b = {{12{b[19]}}, b[19:0]};
      end
      r          = expected_result(op, a, b);
      vectors[i] = vector_row(op, a, b, r.value, r.overflow);
    end

    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    // Idle status out of reset
    apb_read(scalar_bus_pkg::STATUS, rdata, err);
    compare("status", rdata, '0);
    finish_test("reset status");

    // Table loop
    for (int i = 0; i < N_TESTS && !timed_out; i++) begin
      load_operands(vectors[i].a, vectors[i].b);
      start_op(vectors[i].op, stall);
      wait_done();
      apb_read(scalar_bus_pkg::RESULT, rdata, err);
      compare("result", rdata, vectors[i].exp_value);
      // Expected overflow with done set and busy clear
      apb_read(scalar_bus_pkg::STATUS, rdata, err);
      compare("status", rdata, {{(W-3){1'b0}}, vectors[i].exp_ovf, 2'b10});
      finish_test($sformatf("%0d %s", i, vectors[i].op.name()));
    end

    // Add started while a multiply runs
    load_operands(32'h00030000, 32'hFFFE0000);
    start_op(scalar_arith_pkg::OP_MUL, stall);
    load_operands(32'h00010000, 32'h00020000);
    start_op(scalar_arith_pkg::OP_ADD, stall);
    if (!timed_out && stall == 0) begin
      $display("Add start was not held off while the multiply was busy");
      test_errors++;
    end
    // Result register still holds the product here
    apb_read(scalar_bus_pkg::RESULT, rdata, err);
    compare("result", rdata, 32'hFFFA0000);
    wait_done();
    apb_read(scalar_bus_pkg::RESULT, rdata, err);
    compare("result", rdata, 32'h00030000);
    apb_read(scalar_bus_pkg::STATUS, rdata, err);
    compare("status", rdata, 32'h00000002);
    finish_test("start while busy");

    // Bus errors leave the result alone
    apb_write(scalar_bus_pkg::RESULT, 32'hDEADBEEF, err, stall);
    compare("pslverr", err, 1);
    apb_write(scalar_bus_pkg::STATUS, 32'h00000007, err, stall);
    compare("pslverr", err, 1);
    apb_read(8'h14, rdata, err);
    compare("pslverr", err, 1);
    apb_write(8'h40, 32'h12345678, err, stall);
    compare("pslverr", err, 1);
    apb_read(scalar_bus_pkg::RESULT, rdata, err);
    compare("pslverr", err, 0);
    compare("result", rdata, 32'h00030000);
    finish_test("bus errors");

    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             pass_count + fail_count, pass_count, fail_count,
             dut.u_control.u_sva.assert_failures);
    if (fail_count == 0 && !timed_out && dut.u_control.u_sva.assert_failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+rtl
rtl/scalar_bus_pkg.sv
rtl/scalar_arith_pkg.sv
rtl/scalar_fixed_adder.sv
rtl/scalar_fixed_multiplier.sv
rtl/scalar_control.sv
rtl/scalar_accelerator.sv
testbench/scalar_accelerator_sva.sv
testbench/scalar_accelerator_tb.sv

/* Makefile */
SIM = obj_dir/Vscalar_accelerator_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module scalar_accelerator_tb \
		-o Vscalar_accelerator_tb
	./$(SIM) > sim.log 2>&1 || (cat sim.log; false)
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
